// ==== hdl/la32_pkg.sv ====
`default_nettype none

package la32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // opcode fields, each compared against its own slice of the word
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;
    localparam logic [5:0]  OPC_BNE     = 6'h17;

    // {pc, inst}
    localparam int FS2DS_W  = 2 * XLEN;
    // {pc, src1, src2, st_data, dest, rf_we, is_load, is_store, is_sub}
    localparam int DS2ES_W  = 4 * XLEN + REG_ADDR_W + 4;
    // {pc, alu_res, dest, rf_we, is_load, is_mem}
    localparam int ES2MS_W  = 2 * XLEN + REG_ADDR_W + 3;
    // {pc, result, dest, rf_we}
    localparam int MS2WS_W  = 2 * XLEN + REG_ADDR_W + 1;
    // {valid, load_pending, dest, value}
    localparam int RF_FWD_W = XLEN + REG_ADDR_W + 2;
    // {taken, target}
    localparam int BR_W     = XLEN + 1;

    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [REG_ADDR_W-1:0] rk;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } ri12;
    } la32_inst_u;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    output logic                         inst_sram_req,
    output logic [la32_pkg::XLEN-1:0]    inst_sram_addr,
    input  logic                         inst_sram_addr_ok,
    input  logic                         inst_sram_data_ok,
    input  logic [la32_pkg::XLEN-1:0]    inst_sram_rdata,
    input  logic                         ds_allowin,
    input  logic [la32_pkg::BR_W-1:0]    br_info,
    output logic                         fs2ds_valid,
    output logic [la32_pkg::FS2DS_W-1:0] fs2ds_bus
);
    import la32_pkg::*;

    logic            req_r;
    logic            outstanding;
    logic            discard;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] req_pc;
    logic            out_valid;
    logic [XLEN-1:0] out_pc;
    logic [XLEN-1:0] out_inst;
    logic            buf_valid;
    logic [XLEN-1:0] buf_pc;
    logic [XLEN-1:0] buf_inst;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] next_pc;
    logic            ret;
    logic            keep;
    logic            idle_next;
    logic            buf_next;
    logic            issue;

    assign {br_taken, br_target} = br_info;
    assign next_pc = br_taken ? br_target : pc;

    // a response is dropped if it was requested before a taken branch
    assign ret  = outstanding & inst_sram_data_ok;
    assign keep = ret & ~discard & ~br_taken;

    // one request in flight at most, and never more than two held words
    assign idle_next = ~req_r & (~outstanding | inst_sram_data_ok);
    assign buf_next  = out_valid & ~ds_allowin & (buf_valid | keep) & ~br_taken;
    assign issue     = idle_next & ~buf_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_r       <= 1'b0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            pc          <= RESET_PC;
            out_valid   <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            req_r       <= issue | (req_r & ~inst_sram_addr_ok);
            outstanding <= (req_r & inst_sram_addr_ok) | (outstanding & ~inst_sram_data_ok);
            if (br_taken) begin
                discard <= req_r | (outstanding & ~inst_sram_data_ok);
            end else if (ret) begin
                discard <= 1'b0;
            end
            pc <= issue ? next_pc + 32'd4 : next_pc;
            if (br_taken) begin
                out_valid <= 1'b0;
            end else if (!out_valid || ds_allowin) begin
                out_valid <= buf_valid | keep;
            end
            buf_valid <= buf_next;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= next_pc;
        end
        if (!out_valid || ds_allowin) begin
            out_pc   <= buf_valid ? buf_pc : req_pc;
            out_inst <= buf_valid ? buf_inst : inst_sram_rdata;
        end
        // decode stalled, park the returning word
        if (out_valid && !ds_allowin && keep) begin
            buf_pc   <= req_pc;
            buf_inst <= inst_sram_rdata;
        end
    end

    assign inst_sram_req  = req_r;
    assign inst_sram_addr = req_pc;
    assign fs2ds_valid    = out_valid;
    assign fs2ds_bus      = {out_pc, out_inst};

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          fs2ds_valid,
    input  logic [la32_pkg::FS2DS_W-1:0]  fs2ds_bus,
    output logic                          ds_allowin,
    output logic [la32_pkg::BR_W-1:0]     br_info,
    input  logic                          es_allowin,
    output logic                          ds2es_valid,
    output logic [la32_pkg::DS2ES_W-1:0]  ds2es_bus,
    input  logic [la32_pkg::RF_FWD_W-1:0] es_rf_fwd,
    input  logic [la32_pkg::RF_FWD_W-1:0] ms_rf_fwd,
    input  logic [la32_pkg::RF_FWD_W-1:0] ws_rf_fwd
);
    import la32_pkg::*;

    logic                  ds_valid;
    logic [XLEN-1:0]       ds_pc;
    la32_inst_u            inst;
    logic [XLEN-1:0]       rf [32];
    logic                  is_add, is_sub, is_addi, is_ld, is_st, is_lu12i, is_beq, is_bne;
    logic                  is_br;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] r2;
    logic                  pend1, pend2;
    logic [XLEN-1:0]       val1, val2;
    logic                  ds_ready_go;
    logic [XLEN-1:0]       imm12;
    logic [XLEN-1:0]       src1, src2;
    logic                  rf_we;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;

    // youngest producer wins; returns {load_pending, value}
    function automatic logic [XLEN:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] a,
        input logic [XLEN-1:0]       rf_val,
        input logic [RF_FWD_W-1:0]   e,
        input logic [RF_FWD_W-1:0]   m,
        input logic [RF_FWD_W-1:0]   w
    );
        logic [RF_FWD_W-1:0] f [3];
        logic [XLEN:0]       r;
        f = '{e, m, w};
        r = {1'b0, rf_val};
        for (int i = 2; i >= 0; i--) begin
            if (f[i][RF_FWD_W-1] && f[i][XLEN +: REG_ADDR_W] == a) begin
                r = {f[i][RF_FWD_W-2], f[i][XLEN-1:0]};
            end
        end
        if (a == '0) begin
            r = '0;
        end
        return r;
    endfunction

    assign is_add   = inst.r3.opcode == OPC_ADD_W;
    assign is_sub   = inst.r3.opcode == OPC_SUB_W;
    assign is_addi  = inst.ri12.opcode == OPC_ADDI_W;
    assign is_ld    = inst.ri12.opcode == OPC_LD_W;
    assign is_st    = inst.ri12.opcode == OPC_ST_W;
    assign is_lu12i = inst[31:25] == OPC_LU12I_W;
    assign is_beq   = inst[31:26] == OPC_BEQ;
    assign is_bne   = inst[31:26] == OPC_BNE;
    assign is_br    = is_beq | is_bne;

    // second source is rk for 3R, rd for stores and branches
    assign rj = inst.r3.rj;
    assign r2 = (is_add | is_sub) ? inst.r3.rk : inst.r3.rd;

    assign {pend1, val1} = fwd_pick(rj, rf[rj], es_rf_fwd, ms_rf_fwd, ws_rf_fwd);
    assign {pend2, val2} = fwd_pick(r2, rf[r2], es_rf_fwd, ms_rf_fwd, ws_rf_fwd);

    // load-use interlock
    assign ds_ready_go = ~((~is_lu12i & pend1) | ((is_add | is_sub | is_st | is_br) & pend2));
    assign ds_allowin  = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds2es_valid = ds_valid & ds_ready_go;

    assign imm12 = {{20{inst.ri12.imm[11]}}, inst.ri12.imm};
    assign src1  = is_lu12i ? '0 : val1;
    assign src2  = (is_add | is_sub) ? val2 :
                   is_lu12i          ? {inst[24:5], 12'b0} : imm12;
    assign rf_we = is_add | is_sub | is_addi | is_lu12i | is_ld;

    assign br_taken  = ds2es_valid & es_allowin &
                       ((is_beq & (val1 == val2)) | (is_bne & (val1 != val2)));
    assign br_target = ds_pc + {{14{inst[25]}}, inst[25:10], 2'b00};
    assign br_info   = {br_taken, br_target};

    assign ds2es_bus = {ds_pc, src1, src2, val2, inst.r3.rd, rf_we, is_ld, is_st, is_sub};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // the word behind a taken branch is wrong path
            ds_valid <= fs2ds_valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs2ds_valid && ds_allowin) begin
            {ds_pc, inst} <= fs2ds_bus;
        end
        if (ws_rf_fwd[RF_FWD_W-1]) begin
            rf[ws_rf_fwd[XLEN +: REG_ADDR_W]] <= ws_rf_fwd[XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ds2es_valid,
    input  logic [la32_pkg::DS2ES_W-1:0]  ds2es_bus,
    output logic                          es_allowin,
    input  logic                          ms_allowin,
    output logic                          es2ms_valid,
    output logic [la32_pkg::ES2MS_W-1:0]  es2ms_bus,
    output logic [la32_pkg::RF_FWD_W-1:0] es_rf_fwd,
    output logic                          data_sram_req,
    output logic                          data_sram_wr,
    output logic [la32_pkg::XLEN-1:0]     data_sram_addr,
    output logic [la32_pkg::XLEN-1:0]     data_sram_wdata,
    input  logic                          data_sram_addr_ok
);
    import la32_pkg::*;

    logic                  es_valid;
    logic [XLEN-1:0]       es_pc;
    logic [XLEN-1:0]       es_src1;
    logic [XLEN-1:0]       es_src2;
    logic [XLEN-1:0]       es_st_data;
    logic [REG_ADDR_W-1:0] es_dest;
    logic                  es_rf_we;
    logic                  es_is_load;
    logic                  es_is_store;
    logic                  es_is_sub;
    logic                  es_is_mem;
    logic [XLEN-1:0]       alu_res;
    logic                  es_ready_go;

    assign alu_res   = es_is_sub ? es_src1 - es_src2 : es_src1 + es_src2;
    assign es_is_mem = es_is_load | es_is_store;

    // memory stage is free whenever the request goes out, so an
    // accepted request always moves on in the same cycle
    assign data_sram_req   = es_valid & es_is_mem & ms_allowin;
    assign data_sram_wr    = es_is_store;
    assign data_sram_addr  = alu_res;
    assign data_sram_wdata = es_st_data;

    assign es_ready_go = ~es_is_mem | (data_sram_req & data_sram_addr_ok);
    assign es_allowin  = ~es_valid | (es_ready_go & ms_allowin);
    assign es2ms_valid = es_valid & es_ready_go;

    assign es2ms_bus = {es_pc, alu_res, es_dest, es_rf_we, es_is_load, es_is_mem};
    assign es_rf_fwd = {es_valid & es_rf_we, es_is_load, es_dest, alu_res};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds2es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds2es_valid && es_allowin) begin
            {es_pc, es_src1, es_src2, es_st_data, es_dest,
             es_rf_we, es_is_load, es_is_store, es_is_sub} <= ds2es_bus;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          es2ms_valid,
    input  logic [la32_pkg::ES2MS_W-1:0]  es2ms_bus,
    output logic                          ms_allowin,
    input  logic                          ws_allowin,
    output logic                          ms2ws_valid,
    output logic [la32_pkg::MS2WS_W-1:0]  ms2ws_bus,
    output logic [la32_pkg::RF_FWD_W-1:0] ms_rf_fwd,
    input  logic                          data_sram_data_ok,
    input  logic [la32_pkg::XLEN-1:0]     data_sram_rdata
);
    import la32_pkg::*;

    logic                  ms_valid;
    logic [XLEN-1:0]       ms_pc;
    logic [XLEN-1:0]       ms_alu;
    logic [REG_ADDR_W-1:0] ms_dest;
    logic                  ms_rf_we;
    logic                  ms_is_load;
    logic                  ms_is_mem;
    logic                  ms_ready_go;
    logic [XLEN-1:0]       ms_result;

    assign ms_ready_go = ~ms_is_mem | data_sram_data_ok;
    assign ms_allowin  = ~ms_valid | (ms_ready_go & ws_allowin);
    assign ms2ws_valid = ms_valid & ms_ready_go;

    assign ms_result = ms_is_load ? data_sram_rdata : ms_alu;
    assign ms2ws_bus = {ms_pc, ms_result, ms_dest, ms_rf_we};
    // still pending until the load word shows up
    assign ms_rf_fwd = {ms_valid & ms_rf_we, ms_is_load & ~data_sram_data_ok, ms_dest, ms_result};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es2ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms_valid && ms_allowin) begin
            {ms_pc, ms_alu, ms_dest, ms_rf_we, ms_is_load, ms_is_mem} <= es2ms_bus;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            ms2ws_valid,
    input  logic [la32_pkg::MS2WS_W-1:0]    ms2ws_bus,
    output logic                            ws_allowin,
    output logic [la32_pkg::RF_FWD_W-1:0]   ws_rf_fwd,
    output logic [la32_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [la32_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [la32_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import la32_pkg::*;

    logic                  ws_valid;
    logic [XLEN-1:0]       ws_pc;
    logic [XLEN-1:0]       ws_result;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic                  ws_rf_we;
    logic                  ws_we;

    // retires every cycle, never back-pressures
    assign ws_allowin = 1'b1;

    // r0 writes are dropped here
    assign ws_we     = ws_valid & ws_rf_we & (ws_dest != '0);
    assign ws_rf_fwd = {ws_we, 1'b0, ws_dest, ws_result};

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{ws_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid) begin
            {ws_pc, ws_result, ws_dest, ws_rf_we} <= ms2ws_bus;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/la32_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module la32_pipe (
    input  logic                            clk,
    input  logic                            arst_n,
    output logic                            inst_sram_req,
    output logic [la32_pkg::XLEN-1:0]       inst_sram_addr,
    input  logic                            inst_sram_addr_ok,
    input  logic                            inst_sram_data_ok,
    input  logic [la32_pkg::XLEN-1:0]       inst_sram_rdata,
    output logic                            data_sram_req,
    output logic                            data_sram_wr,
    output logic [la32_pkg::XLEN-1:0]       data_sram_addr,
    output logic [la32_pkg::XLEN-1:0]       data_sram_wdata,
    input  logic                            data_sram_addr_ok,
    input  logic                            data_sram_data_ok,
    input  logic [la32_pkg::XLEN-1:0]       data_sram_rdata,
    output logic [la32_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [la32_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [la32_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import la32_pkg::*;

    logic                ds_allowin, es_allowin, ms_allowin, ws_allowin;
    logic                fs2ds_valid, ds2es_valid, es2ms_valid, ms2ws_valid;
    logic [FS2DS_W-1:0]  fs2ds_bus;
    logic [DS2ES_W-1:0]  ds2es_bus;
    logic [ES2MS_W-1:0]  es2ms_bus;
    logic [MS2WS_W-1:0]  ms2ws_bus;
    logic [BR_W-1:0]     br_info;
    logic [RF_FWD_W-1:0] es_rf_fwd, ms_rf_fwd, ws_rf_fwd;

    fetch_stage u_fetch (
        .clk(clk), .arst_n(arst_n),
        .inst_sram_req(inst_sram_req), .inst_sram_addr(inst_sram_addr),
        .inst_sram_addr_ok(inst_sram_addr_ok), .inst_sram_data_ok(inst_sram_data_ok),
        .inst_sram_rdata(inst_sram_rdata),
        .ds_allowin(ds_allowin), .br_info(br_info),
        .fs2ds_valid(fs2ds_valid), .fs2ds_bus(fs2ds_bus)
    );

    decode_stage u_decode (
        .clk(clk), .arst_n(arst_n),
        .fs2ds_valid(fs2ds_valid), .fs2ds_bus(fs2ds_bus),
        .ds_allowin(ds_allowin), .br_info(br_info),
        .es_allowin(es_allowin), .ds2es_valid(ds2es_valid), .ds2es_bus(ds2es_bus),
        .es_rf_fwd(es_rf_fwd), .ms_rf_fwd(ms_rf_fwd), .ws_rf_fwd(ws_rf_fwd)
    );

    execute_stage u_execute (
        .clk(clk), .arst_n(arst_n),
        .ds2es_valid(ds2es_valid), .ds2es_bus(ds2es_bus), .es_allowin(es_allowin),
        .ms_allowin(ms_allowin), .es2ms_valid(es2ms_valid), .es2ms_bus(es2ms_bus),
        .es_rf_fwd(es_rf_fwd),
        .data_sram_req(data_sram_req), .data_sram_wr(data_sram_wr),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_addr_ok(data_sram_addr_ok)
    );

    memory_stage u_memory (
        .clk(clk), .arst_n(arst_n),
        .es2ms_valid(es2ms_valid), .es2ms_bus(es2ms_bus), .ms_allowin(ms_allowin),
        .ws_allowin(ws_allowin), .ms2ws_valid(ms2ws_valid), .ms2ws_bus(ms2ws_bus),
        .ms_rf_fwd(ms_rf_fwd),
        .data_sram_data_ok(data_sram_data_ok), .data_sram_rdata(data_sram_rdata)
    );

    writeback_stage u_writeback (
        .clk(clk), .arst_n(arst_n),
        .ms2ws_valid(ms2ws_valid), .ms2ws_bus(ms2ws_bus), .ws_allowin(ws_allowin),
        .ws_rf_fwd(ws_rf_fwd),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/la32_pipe_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module la32_pipe_sva (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            inst_sram_req,
    input logic [la32_pkg::XLEN-1:0]       inst_sram_addr,
    input logic                            inst_sram_addr_ok,
    input logic                            data_sram_req,
    input logic                            data_sram_wr,
    input logic [la32_pkg::XLEN-1:0]       data_sram_addr,
    input logic [la32_pkg::XLEN-1:0]       data_sram_wdata,
    input logic                            data_sram_addr_ok,
    input logic [3:0]                      debug_wb_rf_we,
    input logic [la32_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    input logic [la32_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    int fail_count = 0;

    // request held until accepted
    assert property (@(posedge clk) disable iff (!arst_n)
        inst_sram_req && !inst_sram_addr_ok |=> inst_sram_req && $stable(inst_sram_addr))
    else begin
        $error("inst_sram request dropped or changed before addr_ok");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        data_sram_req && !data_sram_addr_ok |=> data_sram_req && $stable(data_sram_wr)
            && $stable(data_sram_addr) && (!data_sram_wr || $stable(data_sram_wdata)))
    else begin
        $error("data_sram request dropped or changed before addr_ok");
        fail_count++;
    end

    assert property (@(posedge clk) !arst_n |-> !inst_sram_req && !data_sram_req)
    else begin
        $error("memory request raised during reset");
        fail_count++;
    end

    // a retiring write carries a known register number and value
    assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb_rf_we != 4'h0 |-> !$isunknown({debug_wb_rf_wnum, debug_wb_rf_wdata}))
    else begin
        $error("unknown register number or value on a retiring write");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/la32_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module la32_pipe_tb;
    import la32_pkg::*;

    localparam int PROG_LEN     = 26;
    localparam int N_RETIRE     = 60;
    localparam int STEP_TIMEOUT = 200;
    localparam int N_TESTS      = 5;

    logic        clk;
    logic        arst_n;
    logic        inst_sram_addr_ok, inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_addr_ok, data_sram_data_ok;
    logic [31:0] data_sram_rdata;
    wire         inst_sram_req, data_sram_req, data_sram_wr;
    wire  [31:0] inst_sram_addr, data_sram_addr, data_sram_wdata;
    wire  [31:0] debug_wb_pc, debug_wb_rf_wdata;
    wire  [3:0]  debug_wb_rf_we;
    wire  [4:0]  debug_wb_rf_wnum;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] mmem [logic [31:0]];
    logic [31:0] regs [32];
    logic [31:0] rng = 32'h2626;
    int          iq_cnt[$], dq_cnt[$];
    logic [31:0] iq_val[$], dq_val[$];
    int          i_wait, d_wait;
    string       names [N_TESTS] = '{"alu", "forwarding", "store_load", "r0_write", "branch"};
    int          checks [N_TESTS];
    int          errs [N_TESTS];

    la32_pipe u_la32_pipe (.*);

    bind la32_pipe la32_pipe_sva u_sva (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] opc, input int rd, rj, rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] opc, input int rd, rj, imm);
        return {opc, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_lu12i(input int rd, input int imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    // offs counts instructions, compares rj against rd
    function automatic logic [31:0] enc_br(input logic [5:0] opc, input int rj, rd, offs);
        return {opc, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    // unwritten data words
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6b3c_91e5;
    endfunction

    function automatic logic [31:0] imem_word(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - RESET_PC) >> 2;
        if (a >= RESET_PC && idx < PROG_LEN) begin
            return prog[idx];
        end
        return 32'h0280_0000;
    endfunction

    function automatic int test_of(input int idx);
        if (idx >= 2 && idx <= 5) return 1;
        if ((idx >= 9 && idx <= 11) || (idx >= 20 && idx <= 23)) return 2;
        if (idx == 12 || idx == 13) return 3;
        if (idx >= 14) return 4;
        return 0;
    endfunction

    // ISA reference, one instruction per call
    task automatic step_model(inout logic [31:0] pc, output logic we,
                              output logic [4:0] rd, output logic [31:0] val);
        logic [31:0] w, a, b, d, si12, next;
        w    = imem_word(pc);
        rd   = w[4:0];
        a    = regs[w[9:5]];
        b    = regs[w[14:10]];
        d    = regs[w[4:0]];
        si12 = {{20{w[21]}}, w[21:10]};
        next = pc + 32'd4;
        we   = 1'b0;
        val  = '0;
        if (w[31:15] == 17'h00020) begin
            we  = 1'b1;
            val = a + b;
        end else if (w[31:15] == 17'h00022) begin
            we  = 1'b1;
            val = a - b;
        end else if (w[31:22] == 10'h00a) begin
            we  = 1'b1;
            val = a + si12;
        end else if (w[31:22] == 10'h0a2) begin
            we  = 1'b1;
            val = mmem.exists(a + si12) ? mmem[a + si12] : fill_word(a + si12);
        end else if (w[31:22] == 10'h0a6) begin
            mmem[a + si12] = d;
        end else if (w[31:25] == 7'h0a) begin
            we  = 1'b1;
            val = {w[24:5], 12'b0};
        end else if ((w[31:26] == 6'h16 && a == d) || (w[31:26] == 6'h17 && a != d)) begin
            next = pc + {{14{w[25]}}, w[25:10], 2'b00};
        end
        if (rd == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            regs[rd] = val;
        end
        pc = next;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // both memories, random accept and response delays
    always @(posedge clk) begin
        if (!arst_n) begin
            inst_sram_addr_ok <= 1'b0;
            inst_sram_data_ok <= 1'b0;
            data_sram_addr_ok <= 1'b0;
            data_sram_data_ok <= 1'b0;
            iq_cnt.delete();
            iq_val.delete();
            dq_cnt.delete();
            dq_val.delete();
            i_wait = 0;
            d_wait = 0;
        end else begin
            if (inst_sram_req && inst_sram_addr_ok) begin
                iq_val.push_back(imem_word(inst_sram_addr));
                rng = xorshift(rng);
                iq_cnt.push_back(int'(rng[1:0]));
                rng = xorshift(rng);
                i_wait = int'(rng[1:0]);
                inst_sram_addr_ok <= 1'b0;
            end else if (inst_sram_req) begin
                if (i_wait == 0) inst_sram_addr_ok <= 1'b1;
                else i_wait = i_wait - 1;
            end
            if (data_sram_req && data_sram_addr_ok) begin
                if (data_sram_wr) begin
                    dmem[data_sram_addr] = data_sram_wdata;
                    dq_val.push_back(32'h0);
                end else begin
                    dq_val.push_back(dmem.exists(data_sram_addr) ?
                                     dmem[data_sram_addr] : fill_word(data_sram_addr));
                end
                rng = xorshift(rng);
                dq_cnt.push_back(int'(rng[1:0]));
                rng = xorshift(rng);
                d_wait = int'(rng[1:0]);
                data_sram_addr_ok <= 1'b0;
            end else if (data_sram_req) begin
                if (d_wait == 0) data_sram_addr_ok <= 1'b1;
                else d_wait = d_wait - 1;
            end
            inst_sram_data_ok <= 1'b0;
            if (iq_cnt.size() > 0) begin
                if (iq_cnt[0] == 0) begin
                    inst_sram_data_ok <= 1'b1;
                    inst_sram_rdata   <= iq_val.pop_front();
                    void'(iq_cnt.pop_front());
                end else begin
                    iq_cnt[0] = iq_cnt[0] - 1;
                end
            end
            data_sram_data_ok <= 1'b0;
            if (dq_cnt.size() > 0) begin
                if (dq_cnt[0] == 0) begin
                    data_sram_data_ok <= 1'b1;
                    data_sram_rdata   <= dq_val.pop_front();
                    void'(dq_cnt.pop_front());
                end else begin
                    dq_cnt[0] = dq_cnt[0] - 1;
                end
            end
        end
    end

    initial begin
        logic [31:0] mpc, exp_pc, exp_val;
        logic        exp_we, found, timed_out;
        logic [4:0]  exp_rd;
        int          cycles, t, total_chk, total_err, sva_err;
        arst_n            = 1'b0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = '0;
        data_sram_addr_ok = 1'b0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        timed_out         = 1'b0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < N_TESTS; i++) begin
            checks[i] = 0;
            errs[i]   = 0;
        end
        prog = '{enc_lu12i(1, 32'h12345), enc_ri12(10'h00a, 2, 0, -5),
                 enc_3r(17'h20, 3, 1, 2), enc_3r(17'h22, 4, 3, 1),
                 enc_ri12(10'h00a, 5, 4, 100), enc_3r(17'h20, 6, 5, 3),
                 enc_lu12i(7, 32'hfffff), enc_ri12(10'h00a, 8, 0, 12'h7ff),
                 enc_lu12i(9, 1), enc_ri12(10'h0a6, 6, 9, 8),
                 enc_ri12(10'h0a2, 10, 9, 8), enc_3r(17'h20, 11, 10, 10),
                 enc_ri12(10'h00a, 0, 1, 5), enc_3r(17'h20, 12, 0, 8),
                 enc_br(6'h16, 11, 11, 2), enc_ri12(10'h00a, 13, 0, 1),
                 enc_br(6'h17, 12, 8, 2), enc_br(6'h17, 12, 7, 2),
                 enc_ri12(10'h00a, 13, 0, 2), enc_br(6'h16, 2, 1, 3),
                 enc_ri12(10'h0a6, 2, 9, -4), enc_ri12(10'h0a2, 14, 9, -4),
                 enc_ri12(10'h0a2, 15, 9, 16), enc_3r(17'h22, 16, 14, 15),
                 enc_ri12(10'h00a, 13, 16, 0), enc_br(6'h16, 0, 0, 0)};
        mpc = RESET_PC;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < N_RETIRE && !timed_out; n++) begin
            cycles = 0;
            found  = 1'b0;
            // writeback valid marks one retire per cycle
            while (!found && cycles < STEP_TIMEOUT) begin
                @(negedge clk);
                cycles++;
                found = u_la32_pipe.u_writeback.ws_valid;
            end
            if (!found) begin
                $display("timeout: nothing retired for %0d cycles after retire %0d", cycles, n);
                timed_out = 1'b1;
            end else begin
                t      = test_of(int'((mpc - RESET_PC) >> 2));
                exp_pc = mpc;
                step_model(mpc, exp_we, exp_rd, exp_val);
                checks[t]++;
                assert (debug_wb_pc == exp_pc) else begin
                    $display("[FAIL] %s pc: expected %h, actual %h", names[t], exp_pc, debug_wb_pc);
                    errs[t]++;
                end
                assert (debug_wb_rf_we == {4{exp_we}}) else begin
                    $display("[FAIL] %s rf_we: expected %h, actual %h",
                             names[t], {4{exp_we}}, debug_wb_rf_we);
                    errs[t]++;
                end
                if (exp_we) begin
                    assert (debug_wb_rf_wnum == exp_rd && debug_wb_rf_wdata == exp_val) else begin
                        $display("[FAIL] %s write: expected r%0d=%h, actual r%0d=%h", names[t],
                                 exp_rd, exp_val, debug_wb_rf_wnum, debug_wb_rf_wdata);
                        errs[t]++;
                    end
                end
            end
        end
        total_chk = 0;
        total_err = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            $display("test %s: %0d retires checked, %0d errors", names[i], checks[i], errs[i]);
            total_chk += checks[i];
            total_err += errs[i];
        end
        sva_err = u_la32_pipe.u_sva.fail_count;
        $display("total: %0d checks, %0d errors, %0d assertion failures, timeout %0d",
                 total_chk, total_err, sva_err, timed_out);
        if (total_err == 0 && sva_err == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== la32_pipe.f ====
hdl/la32_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/writeback_stage.sv
hdl/la32_pipe.sv
tb/la32_pipe_sva.sv
tb/la32_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: la32_pipe

sources:
  - files:
      - hdl/la32_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/writeback_stage.sv
      - hdl/la32_pipe.sv
  - target: test
    files:
      - tb/la32_pipe_sva.sv
      - tb/la32_pipe_tb.sv
